/* Makefile */
# Verilator build and run of the interrupt subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_irq_subsys
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/irq_cfg_regs.sv */
// configuration write decoder
// prescale and min interval registers, vector table write strobe

`timescale 1ns/1ps

module irq_cfg_regs import irq_pkg::*; #(
    parameter int irq_index_width = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  cfg_wr_t   cfg,
    output rate_cfg_t rate_cfg,
    output tbl_wr_t   tbl_wr
);

    // two words per table entry
    localparam int tbl_words = 2 * (2**irq_index_width);

    logic [11:0] tbl_offset;
    logic        tbl_hit;
    rate_cfg_t   rate_cfg_reg;
    tbl_wr_t     tbl_wr_reg;

    assign tbl_offset = cfg.addr - cfg_addr_table;
    assign tbl_hit = cfg.valid && (cfg.addr >= cfg_addr_table)
                     && (tbl_offset < 12'(tbl_words));

    always_ff @(posedge clk) begin
        tbl_wr_reg.valid <= tbl_hit;
        if (tbl_hit) begin
            // low address bit picks address or data
            tbl_wr_reg.index <= tbl_offset[8:1];
            tbl_wr_reg.sel <= tbl_offset[0];
            tbl_wr_reg.data <= cfg.data;
        end

        if (cfg.valid) begin
            case (cfg.addr)
                cfg_addr_prescale: rate_cfg_reg.prescale <= cfg.data[15:0];
                cfg_addr_interval: rate_cfg_reg.min_interval <= cfg.data[15:0];
                default: begin
                end
            endcase
        end

        if (rst) begin
            rate_cfg_reg <= '0;
            tbl_wr_reg.valid <= 1'b0;
        end
    end

    assign rate_cfg = rate_cfg_reg;
    assign tbl_wr = tbl_wr_reg;

endmodule

/* design/irq_edge_collect.sv */
// rising edge capture of the interrupt lines into pending bits
// round-robin selection of a pending bit into a registered index stream

`timescale 1ns/1ps

module irq_edge_collect #(
    parameter int irq_index_width = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [2**irq_index_width-1:0] irq_lines,
    output logic [irq_index_width-1:0] in_index,
    output logic                       in_valid,
    input  logic                       in_ready
);

    localparam int n_src = 2**irq_index_width;

    logic [n_src-1:0]           lines_reg;
    logic [n_src-1:0]           pending_reg;
    logic [n_src-1:0]           rise;
    logic [n_src-1:0]           clr;
    logic [irq_index_width-1:0] last_grant_reg;
    logic [irq_index_width-1:0] cand;
    logic [irq_index_width-1:0] sel_index;
    logic                       sel_found;
    logic [irq_index_width-1:0] index_reg;
    logic                       valid_reg;
    logic                       xfer;

    assign rise = irq_lines & ~lines_reg;
    assign xfer = valid_reg && in_ready;
    assign clr  = xfer ? (n_src'(1) << index_reg) : '0;

    // first pending index after the last grant, wrapping around
    always_comb begin
        sel_found = 1'b0;
        sel_index = last_grant_reg;
        cand = last_grant_reg;
        for (int k = 1; k <= n_src; k++) begin
            cand = last_grant_reg + irq_index_width'(k);
            if (!sel_found && pending_reg[cand]) begin
                sel_found = 1'b1;
                sel_index = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        lines_reg <= irq_lines;
        // a new edge on a pending index just merges into the bit
        pending_reg <= (pending_reg & ~clr) | rise;

        if (!valid_reg && sel_found) begin
            valid_reg <= 1'b1;
            index_reg <= sel_index;
            last_grant_reg <= sel_index;
        end else if (xfer) begin
            valid_reg <= 1'b0;
        end

        if (rst) begin
            // take the current levels so a line held high is no edge
            lines_reg <= irq_lines;
            pending_reg <= '0;
            valid_reg <= 1'b0;
            last_grant_reg <= '1;
        end
    end

    assign in_index = index_reg;
    assign in_valid = valid_reg;

endmodule

/* design/irq_msg_gen.sv */
// vector table lookup for accepted interrupt indices
// address and data tables plus the registered message output

`timescale 1ns/1ps

module irq_msg_gen import irq_pkg::*; #(
    parameter int irq_index_width = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [irq_index_width-1:0] out_index,
    input  logic                       out_valid,
    output logic                       out_ready,
    input  tbl_wr_t                    tbl_wr,
    output irq_msg_t                   msg,
    output logic                       msg_valid,
    input  logic                       msg_ready
);

    localparam int n_src = 2**irq_index_width;

    logic [31:0]                addr_tbl [n_src];
    logic [31:0]                data_tbl [n_src];
    logic [irq_index_width-1:0] wr_index;
    irq_msg_t                   msg_reg;
    logic                       msg_valid_reg;
    logic                       load;

    assign wr_index = tbl_wr.index[irq_index_width-1:0];

    // table writes
    always_ff @(posedge clk) begin
        if (tbl_wr.valid) begin
            if (tbl_wr.sel) begin
                data_tbl[wr_index] <= tbl_wr.data;
            end else begin
                addr_tbl[wr_index] <= tbl_wr.data;
            end
        end
    end

    // accept when empty or when the held message leaves this cycle
    assign out_ready = !msg_valid_reg || msg_ready;
    assign load = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (load) begin
            msg_reg.addr <= addr_tbl[out_index];
            msg_reg.data <= data_tbl[out_index];
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            msg_valid_reg <= 1'b1;
        end else if (msg_ready) begin
            msg_valid_reg <= 1'b0;
        end

        if (rst) begin
            msg_valid_reg <= 1'b0;
        end
    end

    assign msg = msg_reg;
    assign msg_valid = msg_valid_reg;

endmodule

/* design/irq_pkg.sv */
// shared types for the interrupt delivery subsystem
// rate settings, message write, config write and vector table write
// plus the configuration address map

package irq_pkg;

    // coarse time and timer width, one bit above min_interval for the sign test
    localparam int time_width = 17;

    // configuration address map
    localparam logic [11:0] cfg_addr_prescale = 12'h000;
    localparam logic [11:0] cfg_addr_interval = 12'h001;
    localparam logic [11:0] cfg_addr_table    = 12'h100;

    typedef struct packed {
        logic [15:0] prescale;      // extra clocks per time tick
        logic [15:0] min_interval;  // in ticks, zero disables limiting
    } rate_cfg_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } irq_msg_t;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;
        logic [31:0] data;
    } cfg_wr_t;

    typedef struct packed {
        logic        valid;
        logic [7:0]  index;
        logic        sel;   // 0 writes the address entry, 1 the data entry
        logic [31:0] data;
    } tbl_wr_t;

endpackage

/* design/irq_rate_limit.sv */
// per-index minimum interval limiter
// prescaled time base, timer memory with running and pending bits,
// and an FSM that serves new requests and scans for expired timers

`timescale 1ns/1ps

module irq_rate_limit import irq_pkg::*; #(
    parameter int irq_index_width = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [irq_index_width-1:0] in_index,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic [irq_index_width-1:0] out_index,
    output logic                       out_valid,
    input  logic                       out_ready,
    input  rate_cfg_t                  rate_cfg
);

    localparam int n_src = 2**irq_index_width;

    typedef enum logic [1:0] {
        st_init,
        st_idle,
        st_input,
        st_output
    } state_t;

    typedef struct packed {
        logic [time_width-1:0] expire;
        logic                  running;
        logic                  pending;
    } timer_entry_t;

    state_t state_reg;
    state_t state_next;

    logic [irq_index_width-1:0] cur_index_reg;
    logic [irq_index_width-1:0] cur_index_next;
    logic [irq_index_width-1:0] irq_index_reg;
    logic [irq_index_width-1:0] irq_index_next;
    logic                       in_ready_reg;
    logic                       in_ready_next;
    logic [irq_index_width-1:0] out_index_reg;
    logic [irq_index_width-1:0] out_index_next;
    logic                       out_valid_reg;
    logic                       out_valid_next;

    timer_entry_t               mem [n_src];
    timer_entry_t               mem_rd_data;
    timer_entry_t               mem_wr_data;
    timer_entry_t               restart_entry;
    logic                       mem_rd_en;
    logic                       mem_wr_en;
    logic [irq_index_width-1:0] mem_addr;
    logic                       rd_valid_reg;
    logic                       rd_valid_next;

    logic [15:0]                prescale_cnt;
    logic [time_width-1:0]      time_cnt;
    logic [time_width-1:0]      time_diff;
    logic                       can_send;
    logic                       expired;

    // coarse time base, one tick every prescale+1 clocks
    always_ff @(posedge clk) begin
        if (prescale_cnt != '0) begin
            prescale_cnt <= prescale_cnt - 16'd1;
        end else begin
            prescale_cnt <= rate_cfg.prescale;
            time_cnt <= time_cnt + time_width'(1);
        end

        if (rst) begin
            prescale_cnt <= '0;
            time_cnt <= '0;
        end
    end

    // negative remaining time means the timer has run out
    assign time_diff = mem_rd_data.expire - time_cnt;
    assign expired = rd_valid_reg && mem_rd_data.running && time_diff[time_width-1];
    assign can_send = !out_valid_reg || out_ready;

    assign restart_entry.expire  = time_cnt + time_width'(rate_cfg.min_interval);
    assign restart_entry.running = rate_cfg.min_interval != '0;
    assign restart_entry.pending = 1'b0;

    always_comb begin
        state_next = state_reg;
        cur_index_next = cur_index_reg;
        irq_index_next = irq_index_reg;
        in_ready_next = 1'b0;
        out_index_next = out_index_reg;
        out_valid_next = out_valid_reg && !out_ready;
        rd_valid_next = rd_valid_reg;
        mem_rd_en = 1'b0;
        mem_wr_en = 1'b0;
        mem_addr = cur_index_reg;
        mem_wr_data = '0;

        case (state_reg)
            st_init: begin
                // clear one entry per cycle
                mem_wr_en = 1'b1;
                cur_index_next = cur_index_reg + irq_index_width'(1);
                if (cur_index_reg == '1) begin
                    in_ready_next = 1'b1;
                    state_next = st_idle;
                end
            end
            st_idle: begin
                in_ready_next = 1'b1;
                if (in_valid && in_ready_reg) begin
                    // new request has priority over the scan
                    irq_index_next = in_index;
                    mem_addr = in_index;
                    mem_rd_en = 1'b1;
                    rd_valid_next = 1'b1;
                    in_ready_next = 1'b0;
                    state_next = st_input;
                end else if (expired) begin
                    in_ready_next = 1'b0;
                    state_next = st_output;
                end else begin
                    // read the next timer in the scan
                    irq_index_next = cur_index_reg;
                    mem_rd_en = 1'b1;
                    rd_valid_next = 1'b1;
                    cur_index_next = cur_index_reg + irq_index_width'(1);
                end
            end
            st_input: begin
                mem_addr = irq_index_reg;
                if (mem_rd_data.running) begin
                    // repeat inside the interval, remember it only
                    mem_wr_data = mem_rd_data;
                    mem_wr_data.pending = 1'b1;
                    mem_wr_en = 1'b1;
                    rd_valid_next = 1'b0;
                    in_ready_next = 1'b1;
                    state_next = st_idle;
                end else if (can_send) begin
                    mem_wr_data = restart_entry;
                    mem_wr_en = 1'b1;
                    rd_valid_next = 1'b0;
                    out_valid_next = 1'b1;
                    out_index_next = irq_index_reg;
                    in_ready_next = 1'b1;
                    state_next = st_idle;
                end
            end
            st_output: begin
                mem_addr = irq_index_reg;
                if (mem_rd_data.pending) begin
                    // deferred delivery, timer starts over
                    if (can_send) begin
                        mem_wr_data = restart_entry;
                        mem_wr_en = 1'b1;
                        rd_valid_next = 1'b0;
                        out_valid_next = 1'b1;
                        out_index_next = irq_index_reg;
                        in_ready_next = 1'b1;
                        state_next = st_idle;
                    end
                end else begin
                    // nothing held back, timer goes idle
                    mem_wr_en = 1'b1;
                    rd_valid_next = 1'b0;
                    in_ready_next = 1'b1;
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_init;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_addr] <= mem_wr_data;
        end else if (mem_rd_en) begin
            mem_rd_data <= mem[mem_addr];
        end
    end

    always_ff @(posedge clk) begin
        state_reg <= state_next;
        cur_index_reg <= cur_index_next;
        irq_index_reg <= irq_index_next;
        in_ready_reg <= in_ready_next;
        out_index_reg <= out_index_next;
        out_valid_reg <= out_valid_next;
        rd_valid_reg <= rd_valid_next;

        if (rst) begin
            state_reg <= st_init;
            cur_index_reg <= '0;
            in_ready_reg <= 1'b0;
            out_valid_reg <= 1'b0;
            rd_valid_reg <= 1'b0;
        end
    end

    assign in_ready = in_ready_reg;
    assign out_index = out_index_reg;
    assign out_valid = out_valid_reg;

endmodule

/* design/irq_subsys_top.sv */
// interrupt delivery subsystem top level
// edge collector, rate limiter, message generator and config decoder

`timescale 1ns/1ps

module irq_subsys_top import irq_pkg::*; #(
    parameter int irq_index_width = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [2**irq_index_width-1:0] irq_lines,
    input  cfg_wr_t                       cfg,
    output irq_msg_t                      msg,
    output logic                          msg_valid,
    input  logic                          msg_ready
);

    logic [irq_index_width-1:0] in_index;
    logic                       in_valid;
    logic                       in_ready;
    logic [irq_index_width-1:0] out_index;
    logic                       out_valid;
    logic                       out_ready;
    rate_cfg_t                  rate_cfg;
    tbl_wr_t                    tbl_wr;

    irq_cfg_regs #(
        .irq_index_width(irq_index_width)
    ) i_cfg_regs (
        .clk(clk),
        .rst(rst),
        .cfg(cfg),
        .rate_cfg(rate_cfg),
        .tbl_wr(tbl_wr)
    );

    irq_edge_collect #(
        .irq_index_width(irq_index_width)
    ) i_edge_collect (
        .clk(clk),
        .rst(rst),
        .irq_lines(irq_lines),
        .in_index(in_index),
        .in_valid(in_valid),
        .in_ready(in_ready)
    );

    irq_rate_limit #(
        .irq_index_width(irq_index_width)
    ) i_rate_limit (
        .clk(clk),
        .rst(rst),
        .in_index(in_index),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_index(out_index),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .rate_cfg(rate_cfg)
    );

    irq_msg_gen #(
        .irq_index_width(irq_index_width)
    ) i_msg_gen (
        .clk(clk),
        .rst(rst),
        .out_index(out_index),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .tbl_wr(tbl_wr),
        .msg(msg),
        .msg_valid(msg_valid),
        .msg_ready(msg_ready)
    );

endmodule

/* sim/tb_irq_subsys.sv */
// testbench for the interrupt delivery subsystem
// table of test rows applied in a loop, message checks against the vector table rule

`timescale 1ns/1ps

module tb_irq_subsys import irq_pkg::*; ();

    localparam int irq_index_width = 4;
    localparam int n_src = 2**irq_index_width;
    localparam int n_rows = 6;
    localparam int quiet_cycles = 400;
    localparam int row_timeout = 6000;
    localparam int init_timeout = 64;

    typedef struct packed {
        logic [15:0] prescale;
        logic [15:0] min_interval;
        logic [15:0] src_mask;
        logic [7:0]  pulses;
        logic [15:0] spacing;     // cycles between rising edges
        logic [2:0]  ready_duty;  // msg_ready high in duty quarters, 4 is always
        logic [7:0]  exp_count;   // messages per pulsed source
        logic [15:0] max_latency; // cycles from pulse to message, 0 skips
    } test_row_t;

    logic            clk;
    logic            rst;
    logic [n_src-1:0] irq_lines;
    cfg_wr_t         cfg;
    irq_msg_t        msg;
    logic            msg_valid;
    logic            msg_ready;

    test_row_t   rows [n_rows];
    string       names [n_rows];
    test_row_t   cur_row;
    int          msg_cnt [n_src];
    int          msg_at [n_src];
    int          last_pulse;
    int          errors;
    int          checks;
    logic        timed_out;
    logic [31:0] rnd_state;

    irq_subsys_top #(
        .irq_index_width(irq_index_width)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .irq_lines(irq_lines),
        .cfg(cfg),
        .msg(msg),
        .msg_valid(msg_valid),
        .msg_ready(msg_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // vector table rule
    function automatic logic [31:0] entry_addr(input int i);
        return 32'h1000 + 32'(4 * i);
    endfunction

    function automatic logic [31:0] expected_data(input int i);
        return 32'hA0 + 32'(i);
    endfunction

    function automatic int addr_to_index(input logic [31:0] addr);
        int found;
        found = -1;
        for (int i = 0; i < n_src; i++) begin
            if (entry_addr(i) == addr) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic load_rows();
        // prescale, min_interval, mask, pulses, spacing, duty, count, latency
        rows[0] = '{16'd0, 16'd100, 16'h0008, 8'd1, 16'd10, 3'd4, 8'd1, 16'd20};
        rows[1] = '{16'd0, 16'd200, 16'h0020, 8'd3, 16'd10, 3'd4, 8'd2, 16'd20};
        rows[2] = '{16'd0, 16'd0, 16'h0100, 8'd4, 16'd40, 3'd4, 8'd4, 16'd20};
        rows[3] = '{16'd1, 16'd30, 16'hFFFF, 8'd1, 16'd10, 3'd4, 8'd1, 16'd0};
        rows[4] = '{16'd1, 16'd30, 16'hFFFF, 8'd1, 16'd10, 3'd1, 8'd1, 16'd0};
        rows[5] = '{16'd1, 16'd20, 16'h0400, 8'd2, 16'd150, 3'd4, 8'd2, 16'd20};
        names[0] = "pass-through";
        names[1] = "coalescing";
        names[2] = "no limiting";
        names[3] = "many sources";
        names[4] = "back-pressure";
        names[5] = "expiry without repeat";
    endtask

    task automatic cfg_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        cfg = '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk);
        #1;
        cfg.valid = 1'b0;
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        @(negedge clk);
        while (!i_dut.in_ready && n < init_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!i_dut.in_ready) begin
            $display("rate limiter init sweep did not finish within %0d cycles", init_timeout);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic program_table();
        for (int i = 0; i < n_src; i++) begin
            cfg_write(cfg_addr_table + 12'(2 * i), entry_addr(i));
            cfg_write(cfg_addr_table + 12'(2 * i + 1), expected_data(i));
        end
    endtask

    task automatic accept_msg(input int cyc);
        int   idx;
        int   min_gap;
        int   settle;
        logic fresh;
        idx = addr_to_index(msg.addr);
        checks++;
        if (idx < 0) begin
            $display("** Error: msg.addr = %h matches no table entry", msg.addr);
            errors++;
        end else begin
            checks++;
            if (msg.data !== expected_data(idx)) begin
                $display("** Error: msg.data = %h, expected %h", msg.data, expected_data(idx));
                errors++;
            end
            if (!cur_row.src_mask[idx]) begin
                $display("message for index %0d, which was not pulsed", idx);
                errors++;
            end
            // one index never delivers twice inside the interval
            min_gap = (int'(cur_row.min_interval) - 1) * (int'(cur_row.prescale) + 1);
            if (cur_row.min_interval != 16'd0 && msg_at[idx] >= 0) begin
                checks++;
                if (cyc - msg_at[idx] < min_gap) begin
                    $display("index %0d delivered again after %0d cycles, minimum %0d",
                             idx, cyc - msg_at[idx], min_gap);
                    errors++;
                end
            end
            // only a repeat inside the interval may be deferred
            settle = (int'(cur_row.min_interval) + 2) * (int'(cur_row.prescale) + 1)
                     + 2 * n_src;
            fresh = msg_at[idx] < 0 || cur_row.min_interval == 16'd0
                    || last_pulse - msg_at[idx] > settle;
            if (cur_row.max_latency != 16'd0 && fresh) begin
                checks++;
                if (cyc - last_pulse > int'(cur_row.max_latency)) begin
                    $display("index %0d delivered %0d cycles after its pulse, limit %0d",
                             idx, cyc - last_pulse, cur_row.max_latency);
                    errors++;
                end
            end
            msg_cnt[idx]++;
            msg_at[idx] = cyc;
        end
    endtask

    task automatic run_row(input int r);
        int       cyc;
        int       quiet;
        int       err_start;
        int       n_msg;
        int       exp_n;
        int       pulse_end;
        int       spacing;
        logic     held_ok;
        logic     done;
        irq_msg_t held;
        cur_row = rows[r];
        err_start = errors;
        cfg_write(cfg_addr_prescale, {16'd0, cur_row.prescale});
        cfg_write(cfg_addr_interval, {16'd0, cur_row.min_interval});
        for (int i = 0; i < n_src; i++) begin
            msg_cnt[i] = 0;
            msg_at[i] = -1;
        end
        spacing = int'(cur_row.spacing);
        pulse_end = int'(cur_row.pulses) * spacing;
        cyc = 0;
        quiet = 0;
        n_msg = 0;
        last_pulse = 0;
        held_ok = 1'b0;
        held = '0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            // two-cycle pulse at the start of each spacing period
            if (cyc < pulse_end && (cyc % spacing) < 2) begin
                irq_lines = cur_row.src_mask;
            end else begin
                irq_lines = '0;
            end
            if (cyc < pulse_end && (cyc % spacing) == 0) begin
                last_pulse = cyc;
            end
            rnd_state = lcg_next(rnd_state);
            msg_ready = {1'b0, rnd_state[17:16]} < cur_row.ready_duty;
            @(negedge clk);
            if (held_ok) begin
                checks++;
                if (!msg_valid) begin
                    $display("msg_valid dropped while the message was stalled");
                    errors++;
                end else if (msg !== held) begin
                    $display("** Error: msg = %h changed under stall, held %h", msg, held);
                    errors++;
                end
            end
            held_ok = msg_valid && !msg_ready;
            held = msg;
            if (msg_valid && msg_ready) begin
                accept_msg(cyc);
                n_msg++;
            end
            if (msg_valid || cyc < pulse_end) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            cyc++;
            if (quiet >= quiet_cycles) begin
                done = 1'b1;
            end else if (cyc >= row_timeout) begin
                $display("test %0d: output still busy after %0d cycles", r, cyc);
                errors++;
                timed_out = 1'b1;
                done = 1'b1;
            end
        end
        for (int i = 0; i < n_src; i++) begin
            exp_n = cur_row.src_mask[i] ? int'(cur_row.exp_count) : 0;
            checks++;
            if (msg_cnt[i] != exp_n) begin
                $display("** Error: msg count[%0d] = %h, expected %h", i, msg_cnt[i], exp_n);
                errors++;
            end
        end
        $display("test %0d %s: %0d messages, %0d errors, %s", r, names[r], n_msg,
                 errors - err_start, (errors == err_start) ? "ok" : "bad");
    endtask

    initial begin
        rst = 1'b1;
        irq_lines = '0;
        cfg = '0;
        msg_ready = 1'b1;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        rnd_state = 32'd75631;
        load_rows();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_init();
        if (!timed_out) begin
            program_table();
        end
        for (int r = 0; r < n_rows; r++) begin
            if (!timed_out) begin
                run_row(r);
            end
        end
        $display("tests %0d, checks %0d, errors %0d", n_rows, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src.f */
design/irq_pkg.sv
design/irq_edge_collect.sv
design/irq_rate_limit.sv
design/irq_msg_gen.sv
design/irq_cfg_regs.sv
design/irq_subsys_top.sv
sim/tb_irq_subsys.sv
